//--- logic/zports_pkg.sv
// z80 port block definitions
package zports_pkg;

	// low address byte of the kept ports
	localparam logic [7:0] PORT_FE         = 8'hFE;
	localparam logic [7:0] PORT_FD         = 8'hFD;    // 7ffd paging, AY when a15 high
	localparam logic [7:0] PORT_FB_COVOX   = 8'hFB;
	localparam logic [7:0] PORT_KJOY       = 8'h1F;
	localparam logic [7:0] PORT_KMOUSE     = 8'hDF;
	localparam logic [7:0] PORT_XT_DEFAULT = 8'hAF;    // extended config port

	// high byte indices behind the extended port
	localparam logic [7:0] XR_XSTAT     = 8'h00;
	localparam logic [7:0] XR_RAMPAGE   = 8'h10;    // four pages, #10 to #13
	localparam logic [7:0] XR_FMADDR    = 8'h15;
	localparam logic [7:0] XR_SYSCONF   = 8'h20;
	localparam logic [7:0] XR_MEMCONF   = 8'h21;
	localparam logic [7:0] XR_FDDVIRT   = 8'h29;
	localparam logic [7:0] XR_INTMASK   = 8'h2A;
	localparam logic [7:0] XR_CACHECONF = 8'h2B;

	// values after reset
	localparam logic [7:0] RST_RAMPAGE0 = 8'h00;
	localparam logic [7:0] RST_RAMPAGE1 = 8'h05;
	localparam logic [7:0] RST_RAMPAGE2 = 8'h02;
	localparam logic [7:0] RST_RAMPAGE3 = 8'h00;
	localparam logic [7:0] RST_MEMCONF  = 8'h04;    // rom mapped, no ram map
	localparam logic [7:0] RST_INTMASK  = 8'h01;    // frame int only
	localparam logic [7:0] RST_SYSCONF  = 8'h00;    // 3.5 MHz

	// 7ffd byte as seen by the classic 128K modes
	typedef struct packed {
		logic [1:0] page_hi;
		logic       lock48;
		logic       rom;
		logic       screen;
		logic [2:0] page;
	} p7ffd_classic_t;

	// 7ffd byte in memconf mode 3, bit 5 extends the page
	typedef struct packed {
		logic [2:0] page_ext;
		logic       rom;
		logic       screen;
		logic [2:0] page;
	} p7ffd_mode3_t;

	// same data byte, decoded by lock mode
	typedef union packed {
		p7ffd_classic_t classic;
		p7ffd_mode3_t   mode3;
	} p7ffd_t;

endpackage

//--- logic/port_decode.sv
// low address port decoder
`timescale 1ns/1ps

module port_decode #(
	parameter logic [7:0] PORT_XT = zports_pkg::PORT_XT_DEFAULT
) (
	input  logic [15:0] a,
	input  logic        iord,
	input  logic        iowr_s,
	input  logic        iord_s,
	input  logic        dos,

	output logic        porthit,
	output logic        external_port,
	output logic        dataout,

	output logic        sel_fe,
	output logic        sel_xt,
	output logic        sel_kjoy,
	output logic        sel_kmouse,

	output logic        xt_wr,
	output logic        xt_rd,
	output logic        p7ffd_wr,
	output logic        beeper_wr,
	output logic        border_wr,
	output logic        covox_wr
);

	import zports_pkg::*;

	logic [7:0] loa;
	logic       hit_fd;
	logic       hit_covox;
	logic       fe_wr;

	assign loa = a[7:0];

	// address compares
	assign sel_fe     = (loa == PORT_FE);
	assign sel_xt     = (loa == PORT_XT);
	assign sel_kjoy   = (loa == PORT_KJOY);
	assign sel_kmouse = (loa == PORT_KMOUSE);
	assign hit_fd     = (loa == PORT_FD);
	assign hit_covox  = (loa == PORT_FB_COVOX);

	// joystick port collides with the floppy ports in dos
	assign porthit = sel_fe || sel_xt || hit_fd || hit_covox
		|| (sel_kjoy && !dos)
		|| sel_kmouse;

	assign external_port = hit_fd && a[15];    // AY lives outside

	assign dataout = porthit && iord && !external_port;

	// write and read strobes
	assign fe_wr    = sel_fe && iowr_s;
	assign xt_wr    = sel_xt && iowr_s;
	assign xt_rd    = sel_xt && iord_s;
	assign p7ffd_wr = hit_fd && !a[15] && iowr_s;
	assign covox_wr = hit_covox && iowr_s;

	// border and beeper share the FE write
	assign beeper_wr = fe_wr;
	assign border_wr = fe_wr;

endmodule

//--- logic/xt_regs.sv
// extended config registers and 128K paging
`timescale 1ns/1ps

module xt_regs (
	input  logic                clk,
	input  logic                rst,
	input  zports_pkg::p7ffd_t  din,
	input  logic [7:0]          a_hi,
	input  logic                xt_wr,
	input  logic                p7ffd_wr,
	input  logic                opfetch,

	output logic [31:0]         xt_page,
	output logic [4:0]          fmaddr,
	output logic [7:0]          sysconf,
	output logic [7:0]          memconf,
	output logic [3:0]          cacheconf,
	output logic [3:0]          fddvirt,
	output logic [7:0]          intmask
);

	import zports_pkg::*;

	logic [7:0] d;              // raw byte view for #AF writes
	logic [7:0] rampage [4];
	logic       lock48;
	logic       m1_lock128;     // opfetch latched lock for mode 2
	logic       mode2;
	logic       mode3;
	logic       lock128;
	logic       page_wr;
	logic [2:0] page_hi_sel;

	assign d = din;

	assign mode2 = (memconf[7:6] == 2'b10);
	assign mode3 = (memconf[7:6] == 2'b11);

	always_comb
	begin
		if (mode2)
			lock128 = m1_lock128;
		else
			lock128 = memconf[6];
	end

	// 7ffd is dead once lock48 is set
	assign page_wr = p7ffd_wr && !lock48;

	// bit 5 widens the upper page in mode 3
	always_comb
	begin
		if (mode3)
			page_hi_sel = din.mode3.page_ext;
		else if (lock128)
			page_hi_sel = 3'b000;
		else
			page_hi_sel = {1'b0, din.classic.page_hi};
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			m1_lock128 <= 1'b0;
		else if (opfetch)
			m1_lock128 <= (d[7] == d[6]);
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rampage[0] <= RST_RAMPAGE0;
			rampage[1] <= RST_RAMPAGE1;
			rampage[2] <= RST_RAMPAGE2;
			rampage[3] <= RST_RAMPAGE3;
			fmaddr     <= 5'd0;
			sysconf    <= RST_SYSCONF;
			memconf    <= RST_MEMCONF;
			cacheconf  <= 4'h0;    // no cache
			fddvirt    <= 4'h0;
			intmask    <= RST_INTMASK;
			lock48     <= 1'b0;
		end
		else if (page_wr)
		begin
			memconf[0] <= din.classic.rom;
			rampage[3] <= {2'b00, page_hi_sel, din.classic.page};
			if (!mode3)
				lock48 <= din.classic.lock48;
		end
		else if (xt_wr)
		begin
			if (a_hi[7:2] == XR_RAMPAGE[7:2])
				rampage[a_hi[1:0]] <= d;

			case (a_hi)
				XR_FMADDR:    fmaddr <= d[4:0];
				XR_SYSCONF:
				begin
					sysconf   <= d;
					cacheconf <= {4{d[2]}};    // cache follows turbo bit
				end
				XR_MEMCONF:   memconf <= d;
				XR_CACHECONF: cacheconf <= d[3:0];
				XR_FDDVIRT:   fddvirt <= d[3:0];
				XR_INTMASK:   intmask <= d;
				default:
				begin
				end
			endcase
		end
	end

	assign xt_page = {rampage[3], rampage[2], rampage[1], rampage[0]};

endmodule

//--- logic/port_read_mux.sv
// port read data mux
`timescale 1ns/1ps

module port_read_mux (
	input  logic        clk,
	input  logic        rst,
	input  logic [7:0]  a_hi,

	input  logic        sel_fe,
	input  logic        sel_xt,
	input  logic        sel_kjoy,
	input  logic        sel_kmouse,
	input  logic        xt_rd,

	input  logic [4:0]  keys_in,
	input  logic        tape_read,
	input  logic [4:0]  kj_in,
	input  logic [7:0]  mus_in,
	input  logic [31:0] xt_page,

	output logic [7:0]  dout
);

	import zports_pkg::*;

	logic pwr_up;    // set until the first status read

	always_ff @(posedge clk)
	begin
		if (rst)
			pwr_up <= 1'b1;
		else if (xt_rd && (a_hi == XR_XSTAT))
			pwr_up <= 1'b0;
	end

	// extended port readback
	logic [7:0] xt_dout;

	always_comb
	begin
		case (a_hi)
			XR_XSTAT:            xt_dout = {1'b0, pwr_up, 6'b000000};
			XR_RAMPAGE + 8'd2:   xt_dout = xt_page[23:16];
			XR_RAMPAGE + 8'd3:   xt_dout = xt_page[31:24];
			default:             xt_dout = 8'hFF;
		endcase
	end

	always_comb
	begin
		if (sel_fe)
			dout = {1'b1, tape_read, 1'b0, keys_in};
		else if (sel_xt)
			dout = xt_dout;
		else if (sel_kjoy)
			dout = {3'b000, kj_in};
		else if (sel_kmouse)
			dout = mus_in;
		else
			dout = 8'hFF;    // floating bus
	end

endmodule

//--- logic/zports.sv
// z80 I/O port block
`timescale 1ns/1ps

module zports (
	input  logic        clk,
	input  logic        rst,

	input  logic [15:0] a,
	input  logic [7:0]  din,
	output logic [7:0]  dout,
	output logic        dataout,
	input  logic        opfetch,

	input  logic        iord,
	input  logic        iord_s,
	input  logic        iowr_s,
	input  logic        dos,

	output logic        porthit,
	output logic        external_port,
	output logic        border_wr,
	output logic        beeper_wr,
	output logic        covox_wr,

	output logic [31:0] xt_page,
	output logic [4:0]  fmaddr,
	output logic [7:0]  sysconf,
	output logic [7:0]  memconf,
	output logic [3:0]  cacheconf,
	output logic [3:0]  fddvirt,
	output logic [7:0]  intmask,

	input  logic        tape_read,
	input  logic [4:0]  keys_in,    // port FE
	input  logic [4:0]  kj_in,
	input  logic [7:0]  mus_in      // xxDF
);

	import zports_pkg::*;

	logic sel_fe;
	logic sel_xt;
	logic sel_kjoy;
	logic sel_kmouse;
	logic xt_wr;
	logic xt_rd;
	logic p7ffd_wr;

	port_decode #(
		.PORT_XT(PORT_XT_DEFAULT)
	) u_decode (
		.a(a),
		.iord(iord),
		.iowr_s(iowr_s),
		.iord_s(iord_s),
		.dos(dos),
		.porthit(porthit),
		.external_port(external_port),
		.dataout(dataout),
		.sel_fe(sel_fe),
		.sel_xt(sel_xt),
		.sel_kjoy(sel_kjoy),
		.sel_kmouse(sel_kmouse),
		.xt_wr(xt_wr),
		.xt_rd(xt_rd),
		.p7ffd_wr(p7ffd_wr),
		.beeper_wr(beeper_wr),
		.border_wr(border_wr),
		.covox_wr(covox_wr)
	);

	xt_regs u_regs (
		.clk(clk),
		.rst(rst),
		.din(din),
		.a_hi(a[15:8]),
		.xt_wr(xt_wr),
		.p7ffd_wr(p7ffd_wr),
		.opfetch(opfetch),
		.xt_page(xt_page),
		.fmaddr(fmaddr),
		.sysconf(sysconf),
		.memconf(memconf),
		.cacheconf(cacheconf),
		.fddvirt(fddvirt),
		.intmask(intmask)
	);

	port_read_mux u_rdmux (
		.clk(clk),
		.rst(rst),
		.a_hi(a[15:8]),
		.sel_fe(sel_fe),
		.sel_xt(sel_xt),
		.sel_kjoy(sel_kjoy),
		.sel_kmouse(sel_kmouse),
		.xt_rd(xt_rd),
		.keys_in(keys_in),
		.tape_read(tape_read),
		.kj_in(kj_in),
		.mus_in(mus_in),
		.xt_page(xt_page),
		.dout(dout)
	);

endmodule

//--- tb/zports_props.sv
// paging and strobe properties
`timescale 1ns/1ps

module zports_props (
	input logic        clk,
	input logic        rst,
	input logic        xt_wr,
	input logic        p7ffd_wr,
	input logic        lock48,
	input logic [31:0] xt_page,
	input logic [7:0]  memconf
);

	import zports_pkg::*;

	// locked 7ffd write must not move page 3
	locked_page_hold: assert property (@(posedge clk) disable iff (rst)
		(p7ffd_wr && lock48) |=> (xt_page[31:24] == $past(xt_page[31:24])))
		else $error("rampage 3 changed on a 7ffd write while lock48 was set");

	one_write_port: assert property (@(posedge clk) disable iff (rst)
		!(xt_wr && p7ffd_wr))
		else $error("extended port and 7ffd written in the same cycle");

	memconf_after_reset: assert property (@(posedge clk)
		rst |=> (memconf == RST_MEMCONF))
		else $error("memconf not at its reset value after reset");

endmodule

bind xt_regs zports_props u_props (
	.clk(clk),
	.rst(rst),
	.xt_wr(xt_wr),
	.p7ffd_wr(p7ffd_wr),
	.lock48(lock48),
	.xt_page(xt_page),
	.memconf(memconf)
);

//--- tb/zports_tb.sv
// z80 port block testbench
`timescale 1ns/1ps

module zports_tb;

	import zports_pkg::*;

	localparam int N_XT   = 200;    // random extended writes
	localparam int N_PG   = 8;      // 7ffd writes per mode
	localparam int N_LOCK = 8;
	localparam int N_RD   = 200;
	localparam int TEST_CYCLES = 10 + 5 + 2 * N_XT + 4 * (2 + 2 * N_PG) + 2 + N_LOCK + N_RD + 4;

	logic        clk;
	logic        rst;
	logic [15:0] a;
	logic [7:0]  din;
	logic        opfetch;
	logic        iord;
	logic        iord_s;
	logic        iowr_s;
	logic        dos;
	logic        tape_read;
	logic [4:0]  keys_in;
	logic [4:0]  kj_in;
	logic [7:0]  mus_in;
	logic [7:0]  dout;
	logic        dataout;
	logic        porthit;
	logic        external_port;
	logic        border_wr;
	logic        beeper_wr;
	logic        covox_wr;
	logic [31:0] xt_page;
	logic [4:0]  fmaddr;
	logic [7:0]  sysconf;
	logic [7:0]  memconf;
	logic [3:0]  cacheconf;
	logic [3:0]  fddvirt;
	logic [7:0]  intmask;

	// shadow state of the reference model
	logic [7:0]  sh_rp [4];
	logic [4:0]  sh_fmaddr;
	logic [7:0]  sh_sysconf;
	logic [7:0]  sh_memconf;
	logic [3:0]  sh_cacheconf;
	logic [3:0]  sh_fddvirt;
	logic [7:0]  sh_intmask;
	logic        sh_lock48;
	logic        sh_m1;       // opfetch latched lock
	logic        sh_pwr;

	// values expected at the coming rising edge
	logic [31:0] exp_page;
	logic [4:0]  exp_fmaddr;
	logic [7:0]  exp_sysconf;
	logic [7:0]  exp_memconf;
	logic [3:0]  exp_cacheconf;
	logic [3:0]  exp_fddvirt;
	logic [7:0]  exp_intmask;
	logic [7:0]  exp_dout;
	logic [5:0]  exp_flags;
	logic        chk_rd;
	logic        chk_on;

	int          err_cnt;
	int          chk_cnt;
	int          n;
	int          pg_mode;
	logic [7:0]  rnd;
	logic [7:0]  xt_idx [12];
	logic [7:0]  rd_ports [6];

	zports dut0 (.*);

	always #2 clk = ~clk;

	function automatic logic [7:0] expected_dout(input logic [15:0] addr);
		logic [7:0] lo;
		logic [7:0] hi;
		lo = addr[7:0];
		hi = addr[15:8];
		if (lo == PORT_FE)
			return {1'b1, tape_read, 1'b0, keys_in};
		if (lo == PORT_KJOY)
			return {3'b000, kj_in};
		if (lo == PORT_KMOUSE)
			return mus_in;
		if (lo == PORT_XT_DEFAULT)
		begin
			if (hi == XR_XSTAT)
				return {1'b0, sh_pwr, 6'd0};
			if (hi == XR_RAMPAGE + 8'd2)
				return sh_rp[2];
			if (hi == XR_RAMPAGE + 8'd3)
				return sh_rp[3];
		end
		return 8'hFF;    // nothing drives the bus
	endfunction

	// porthit, external_port, dataout, border, beeper, covox
	function automatic logic [5:0] decode_flags(input logic [15:0] addr, input logic dos_v,
		input logic rd, input logic wr);
		logic [7:0] lo;
		logic       hit;
		logic       ext;
		lo = addr[7:0];
		hit = (lo == PORT_FE) || (lo == PORT_XT_DEFAULT) || (lo == PORT_FD)
			|| (lo == PORT_FB_COVOX) || (lo == PORT_KMOUSE) || ((lo == PORT_KJOY) && !dos_v);
		ext = (lo == PORT_FD) && addr[15];
		return {hit, ext, hit && rd && !ext, (lo == PORT_FE) && wr, (lo == PORT_FE) && wr,
			(lo == PORT_FB_COVOX) && wr};
	endfunction

	function automatic logic [7:0] next_page3(input logic [7:0] data);
		logic       lock128;
		logic [2:0] hi3;
		lock128 = (sh_memconf[7:6] == 2'b10) ? sh_m1 : sh_memconf[6];
		if (sh_memconf[7:6] == 2'b11)
			hi3 = data[7:5];    // bit 5 widens the page
		else if (lock128)
			hi3 = 3'b000;
		else
			hi3 = {1'b0, data[7:6]};
		return {2'b00, hi3, data[2:0]};
	endfunction

	task automatic update_model(input logic [15:0] addr, input logic [7:0] data,
		input logic wr, input logic rd, input logic opf);
		logic [7:0] lo;
		logic [7:0] hi;
		lo = addr[7:0];
		hi = addr[15:8];
		if (wr && lo == PORT_FD && !addr[15] && !sh_lock48)
		begin
			sh_rp[3] = next_page3(data);
			if (sh_memconf[7:6] != 2'b11)
				sh_lock48 = data[5];
			sh_memconf[0] = data[4];
		end
		if (wr && lo == PORT_XT_DEFAULT)
		begin
			if (hi >= XR_RAMPAGE && hi <= XR_RAMPAGE + 8'd3)
				sh_rp[2'(hi - XR_RAMPAGE)] = data;
			if (hi == XR_FMADDR)
				sh_fmaddr = data[4:0];
			if (hi == XR_SYSCONF)
			begin
				sh_sysconf = data;
				sh_cacheconf = {4{data[2]}};
			end
			if (hi == XR_MEMCONF)
				sh_memconf = data;
			if (hi == XR_CACHECONF)
				sh_cacheconf = data[3:0];
			if (hi == XR_FDDVIRT)
				sh_fddvirt = data[3:0];
			if (hi == XR_INTMASK)
				sh_intmask = data;
		end
		if (rd && lo == PORT_XT_DEFAULT && hi == XR_XSTAT)
			sh_pwr = 1'b0;
		if (opf)
			sh_m1 = (data[7] == data[6]);
	endtask

	// one bus access driven on the falling edge
	task automatic bus_cycle(input logic [15:0] addr, input logic [7:0] data,
		input logic wr, input logic rd, input logic opf);
		@(negedge clk);
		a = addr;
		din = data;
		iowr_s = wr;
		iord_s = rd;
		iord = rd || (!wr && 1'($urandom));    // read level may run without its strobe
		opfetch = opf;
		dos = 1'($urandom);
		tape_read = 1'($urandom);
		keys_in = 5'($urandom);
		kj_in = 5'($urandom);
		mus_in = 8'($urandom);
		exp_page = {sh_rp[3], sh_rp[2], sh_rp[1], sh_rp[0]};
		exp_fmaddr = sh_fmaddr;
		exp_sysconf = sh_sysconf;
		exp_memconf = sh_memconf;
		exp_cacheconf = sh_cacheconf;
		exp_fddvirt = sh_fddvirt;
		exp_intmask = sh_intmask;
		exp_dout = expected_dout(addr);
		exp_flags = decode_flags(addr, dos, iord, wr);
		chk_rd = rd;
		chk_on = 1'b1;
		update_model(addr, data, wr, rd, opf);
	endtask

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		chk_cnt++;
		assert (got === exp)
		else
		begin
			err_cnt++;
			$display("CHECK FAILED %s: expected %h got %h at %0t", name, exp, got, $time);
		end
	endtask

	always @(posedge clk)
	begin
		if (chk_on)
		begin
			compare_value("xt_page", xt_page, exp_page);
			compare_value("fmaddr", 32'(fmaddr), 32'(exp_fmaddr));
			compare_value("sysconf", 32'(sysconf), 32'(exp_sysconf));
			compare_value("memconf", 32'(memconf), 32'(exp_memconf));
			compare_value("cacheconf", 32'(cacheconf), 32'(exp_cacheconf));
			compare_value("fddvirt", 32'(fddvirt), 32'(exp_fddvirt));
			compare_value("intmask", 32'(intmask), 32'(exp_intmask));
			compare_value("porthit", 32'(porthit), 32'(exp_flags[5]));
			compare_value("external_port", 32'(external_port), 32'(exp_flags[4]));
			compare_value("dataout", 32'(dataout), 32'(exp_flags[3]));
			compare_value("border_wr", 32'(border_wr), 32'(exp_flags[2]));
			compare_value("beeper_wr", 32'(beeper_wr), 32'(exp_flags[1]));
			compare_value("covox_wr", 32'(covox_wr), 32'(exp_flags[0]));
			if (chk_rd)
				compare_value("dout", 32'(dout), 32'(exp_dout));
		end
	end

	initial
	begin
		#(TEST_CYCLES * 4 + 200);
		$display("watchdog timeout: test sequence did not finish in time");
		$display("CHECKS FAILED");
		$finish;
	end

	initial
	begin
		void'($urandom(32'hd2e5f970));
		clk = 1'b0;
		rst = 1'b1;
		a = 16'h0000;
		din = 8'h00;
		opfetch = 1'b0;
		iord = 1'b0;
		iord_s = 1'b0;
		iowr_s = 1'b0;
		dos = 1'b0;
		tape_read = 1'b0;
		keys_in = 5'd0;
		kj_in = 5'd0;
		mus_in = 8'd0;
		chk_on = 1'b0;
		chk_rd = 1'b0;
		err_cnt = 0;
		chk_cnt = 0;
		sh_rp[0] = RST_RAMPAGE0;
		sh_rp[1] = RST_RAMPAGE1;
		sh_rp[2] = RST_RAMPAGE2;
		sh_rp[3] = RST_RAMPAGE3;
		sh_fmaddr = 5'd0;
		sh_sysconf = RST_SYSCONF;
		sh_memconf = RST_MEMCONF;
		sh_cacheconf = 4'h0;
		sh_fddvirt = 4'h0;
		sh_intmask = RST_INTMASK;
		sh_lock48 = 1'b0;
		sh_m1 = 1'b0;
		sh_pwr = 1'b1;
		xt_idx = '{XR_RAMPAGE, XR_RAMPAGE + 8'd1, XR_RAMPAGE + 8'd2, XR_RAMPAGE + 8'd3,
			XR_FMADDR, XR_SYSCONF, XR_MEMCONF, XR_CACHECONF, XR_FDDVIRT, XR_INTMASK,
			XR_XSTAT, 8'h55};
		rd_ports = '{PORT_FE, PORT_KJOY, PORT_KMOUSE, PORT_FD, PORT_FB_COVOX,
			PORT_XT_DEFAULT};

		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// reset values and power-up flag
		bus_cycle(16'h0000, 8'h00, 1'b0, 1'b0, 1'b0);
		bus_cycle({XR_XSTAT, PORT_XT_DEFAULT}, 8'h00, 1'b0, 1'b1, 1'b0);
		bus_cycle({XR_XSTAT, PORT_XT_DEFAULT}, 8'h00, 1'b0, 1'b1, 1'b0);
		bus_cycle({XR_RAMPAGE + 8'd2, PORT_XT_DEFAULT}, 8'h00, 1'b0, 1'b1, 1'b0);
		bus_cycle({XR_RAMPAGE + 8'd3, PORT_XT_DEFAULT}, 8'h00, 1'b0, 1'b1, 1'b0);

		// random extended writes with page readback
		for (n = 0; n < N_XT; n++)
		begin
			bus_cycle({xt_idx[4'($urandom_range(0, 11))], PORT_XT_DEFAULT}, 8'($urandom),
				1'b1, 1'b0, 1'b0);
			bus_cycle({XR_RAMPAGE + 8'd2 + 8'($urandom_range(0, 1)), PORT_XT_DEFAULT}, 8'h00,
				1'b0, 1'b1, 1'b0);
		end

		// 7ffd paging in all four lock modes with lock48 kept clear
		for (pg_mode = 0; pg_mode < 4; pg_mode++)
		begin
			bus_cycle({XR_MEMCONF, PORT_XT_DEFAULT}, {pg_mode[1:0], 6'b000100},
				1'b1, 1'b0, 1'b0);
			bus_cycle(16'hFFFD, 8'($urandom), 1'b1, 1'b0, 1'b0);    // AY write must not page
			for (n = 0; n < N_PG; n++)
			begin
				if (pg_mode == 2)
					bus_cycle(16'h0000, 8'($urandom), 1'b0, 1'b0, 1'b1);
				rnd = 8'($urandom);
				if (pg_mode != 3)
					rnd = rnd & 8'hDF;
				bus_cycle(16'h7FFD, rnd, 1'b1, 1'b0, 1'b0);
			end
		end

		// lock48 freezes further paging
		bus_cycle({XR_MEMCONF, PORT_XT_DEFAULT}, RST_MEMCONF, 1'b1, 1'b0, 1'b0);
		bus_cycle(16'h7FFD, 8'($urandom) | 8'h20, 1'b1, 1'b0, 1'b0);
		for (n = 0; n < N_LOCK; n++)
			bus_cycle(16'h7FFD, 8'($urandom), 1'b1, 1'b0, 1'b0);

		// random port reads and writes over the decoder
		for (n = 0; n < N_RD; n++)
		begin
			rnd = ($urandom_range(0, 6) == 6) ? 8'($urandom) : rd_ports[3'($urandom_range(0, 5))];
			if ($urandom_range(0, 3) == 0)
				bus_cycle({8'($urandom), rnd}, 8'($urandom), 1'b1, 1'b0, 1'b0);
			else
				bus_cycle({8'($urandom), rnd}, 8'h00, 1'b0, 1'($urandom_range(0, 3) != 0), 1'b0);
		end

		bus_cycle(16'h0000, 8'h00, 1'b0, 1'b0, 1'b0);
		@(posedge clk);
		#1;
		chk_on = 1'b0;
		$display("checks run: %0d, errors: %0d", chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

//--- tb.f
logic/zports_pkg.sv
logic/port_decode.sv
logic/xt_regs.sv
logic/port_read_mux.sv
logic/zports.sv
tb/zports_props.sv
tb/zports_tb.sv

//--- Makefile
SRCS := $(shell cat tb.f)

all: run

obj_dir/Vzports_tb: $(SRCS) tb.f
	verilator --binary --timing --assert -j 0 --top-module zports_tb -Mdir obj_dir -f tb.f

run: obj_dir/Vzports_tb
	./obj_dir/Vzports_tb | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
